// File: rtl/stepper_pkg.sv
package stepper_pkg;

  // Axis count and move buffer depth
  localparam int MOTOR_COUNT = 2;
  localparam int MOVE_SLOTS = 2;
  localparam int SLOT_BITS = $clog2(MOVE_SLOTS);

  localparam int WORD_BITS = 64;

  // Accumulator carry into the upper half marks a step
  localparam int STEP_CARRY_BIT = 32;

  // Opcode in the top byte of a message's first word
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE = 8'h0a;
  localparam logic [7:0] CMD_CLK_DIVISOR = 8'h0b;
  localparam logic [7:0] CMD_MOTORCONFIG = 8'h10;
  localparam logic [7:0] CMD_MICROSTEPPER_CONFIG = 8'h16;
  localparam logic [7:0] CMD_CHARGEPUMP = 8'h31;
  localparam logic [7:0] CMD_BRIDGEINVERT = 8'h32;
  localparam logic [7:0] CMD_API_VERSION = 8'hfe;

  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

  // Register values after reset
  localparam logic [2:0] DEF_MICROSTEPS = 3'd2;
  localparam logic [7:0] DEF_CURRENT = 8'd140;
  localparam logic [9:0] DEF_OFFTIME = 10'd810;
  localparam logic [7:0] DEF_BLANKTIME = 8'd27;
  localparam logic [9:0] DEF_FASTDECAY = 10'd706;
  localparam logic [7:0] DEF_MIN_ON_TIME = 8'd54;
  localparam logic [10:0] DEF_CURRENT_THRESHOLD = 11'd1024;
  localparam logic [7:0] DEF_CHARGEPUMP = 8'd91;
  localparam logic DEF_BRIDGE_INVERT = 1'b0;
  localparam logic [7:0] DEF_CLOCK_DIVISOR = 8'd40;

endpackage

// File: rtl/spi_word.sv
`timescale 1ns/1ps

module spi_word (
  input  logic                              CLK,
  input  logic                              resetn,
  input  logic                              sck,
  input  logic                              cs,
  input  logic                              copi,
  input  logic [stepper_pkg::WORD_BITS-1:0] reply_data,
  output logic                              cipo,
  output logic [stepper_pkg::WORD_BITS-1:0] word_data,
  output logic                              word_valid
);

  // Two synchronizer stages plus one for edge detection
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] copi_q;
  logic [$clog2(stepper_pkg::WORD_BITS)-1:0] bit_cnt;
  logic [stepper_pkg::WORD_BITS-1:0] rx_shift;
  logic [stepper_pkg::WORD_BITS-1:0] tx_shift;

  wire sck_rise = sck_q[1] && !sck_q[2];
  wire sck_fall = !sck_q[1] && sck_q[2];
  wire cs_fall = !cs_q[1] && cs_q[2];
  wire selected = !cs_q[1];
  wire last_bit = bit_cnt == ($clog2(stepper_pkg::WORD_BITS))'(stepper_pkg::WORD_BITS - 1);
  wire [stepper_pkg::WORD_BITS-1:0] rx_next = {rx_shift[stepper_pkg::WORD_BITS-2:0], copi_q[1]};

  // MSB first
  assign cipo = tx_shift[stepper_pkg::WORD_BITS-1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q <= '0;
      cs_q <= '1;
      copi_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck};
      cs_q <= {cs_q[1:0], cs};
      copi_q <= {copi_q[0], copi};
    end
  end

  // Count restarts whenever CS is high, so a glitch cannot misalign words
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt <= '0;
      word_valid <= 1'b0;
      tx_shift <= '0;
    end else begin
      word_valid <= selected && sck_rise && last_bit;
      if (!selected) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (cs_fall) begin
        tx_shift <= reply_data;
      end else if (selected && sck_fall) begin
        tx_shift <= {tx_shift[stepper_pkg::WORD_BITS-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (selected && sck_rise) begin
      rx_shift <= rx_next;
      if (last_bit) begin
        word_data <= rx_next;
      end
    end
  end

  // Strobe must stay a single cycle for the decoder
  a_valid_single: assert property (@(posedge CLK) disable iff (!resetn)
    word_valid |=> !word_valid)
    else $error("word_valid high on consecutive cycles");

endmodule

// File: rtl/spi_command_decoder.sv
`timescale 1ns/1ps

module spi_command_decoder (
  input  logic                                         CLK,
  input  logic                                         resetn,
  input  logic [stepper_pkg::WORD_BITS-1:0]            word_data,
  input  logic                                         word_valid,
  input  logic [63:0]                                  encoder_count,
  input  logic [stepper_pkg::MOVE_SLOTS-1:0]           step_finished,
  input  logic [stepper_pkg::SLOT_BITS-1:0]            move_index,
  output logic [stepper_pkg::WORD_BITS-1:0]            reply_data,
  output logic [stepper_pkg::MOTOR_COUNT-1:0]          enable,
  output logic [2:0]                                   microsteps,
  output logic [7:0]                                   current,
  output logic [9:0]                                   config_offtime,
  output logic [7:0]                                   config_blanktime,
  output logic [9:0]                                   config_fastdecay_threshold,
  output logic [7:0]                                   config_minimum_on_time,
  output logic [10:0]                                  config_current_threshold,
  output logic [7:0]                                   config_chargepump_period,
  output logic                                         config_invert_highside,
  output logic                                         config_invert_lowside,
  output logic [7:0]                                   clock_divisor,
  output logic [stepper_pkg::MOVE_SLOTS-1:0]           step_ready,
  output logic [stepper_pkg::SLOT_BITS-1:0]            write_index,
  output logic [63:0]                                  move_duration,
  output logic [stepper_pkg::MOTOR_COUNT-1:0][63:0]    increment,
  output logic [stepper_pkg::MOTOR_COUNT-1:0][63:0]    increment_increment,
  output logic [stepper_pkg::MOTOR_COUNT-1:0]          dir,
  output logic                                         buffer_dtr
);

  logic [7:0] msg_op;
  logic [7:0] word_cnt;

  // Move buffer
  logic [63:0] duration_mem [stepper_pkg::MOVE_SLOTS];
  logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] inc_mem [stepper_pkg::MOVE_SLOTS];
  logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] inc_inc_mem [stepper_pkg::MOVE_SLOTS];
  logic [stepper_pkg::MOTOR_COUNT-1:0] dir_mem [stepper_pkg::MOVE_SLOTS];

  wire [7:0] opcode = word_data[63:56];
  wire in_move = msg_op == stepper_pkg::CMD_COORDINATED_STEP;
  wire in_message = in_move || (msg_op == stepper_pkg::CMD_API_VERSION);

  // Header, duration, then an increment pair per axis
  wire move_commit = word_valid && in_move &&
                     (word_cnt == 8'(2 * stepper_pkg::MOTOR_COUNT + 1));

  assign move_duration = duration_mem[move_index];
  assign increment = inc_mem[move_index];
  assign increment_increment = inc_inc_mem[move_index];
  assign dir = dir_mem[move_index];

  // Slot is free while its toggle bits agree
  assign buffer_dtr = |(step_ready ~^ step_finished);

  always_ff @(posedge CLK) begin
    if (word_valid) begin
      if (!in_message && opcode == stepper_pkg::CMD_COORDINATED_STEP) begin
        dir_mem[write_index] <= word_data[stepper_pkg::MOTOR_COUNT-1:0];
      end
      if (in_move) begin
        if (word_cnt == 8'd1) begin
          duration_mem[write_index] <= word_data;
        end
        for (int a = 0; a < stepper_pkg::MOTOR_COUNT; a++) begin
          if (word_cnt == 8'(2 * a + 2)) begin
            inc_mem[write_index][a] <= word_data;
          end
          if (word_cnt == 8'(2 * a + 3)) begin
            inc_inc_mem[write_index][a] <= word_data;
          end
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      msg_op <= '0;
      word_cnt <= '0;
      reply_data <= '0;
      enable <= '0;
      step_ready <= '0;
      write_index <= '0;
      microsteps <= stepper_pkg::DEF_MICROSTEPS;
      current <= stepper_pkg::DEF_CURRENT;
      config_offtime <= stepper_pkg::DEF_OFFTIME;
      config_blanktime <= stepper_pkg::DEF_BLANKTIME;
      config_fastdecay_threshold <= stepper_pkg::DEF_FASTDECAY;
      config_minimum_on_time <= stepper_pkg::DEF_MIN_ON_TIME;
      config_current_threshold <= stepper_pkg::DEF_CURRENT_THRESHOLD;
      config_chargepump_period <= stepper_pkg::DEF_CHARGEPUMP;
      config_invert_highside <= stepper_pkg::DEF_BRIDGE_INVERT;
      config_invert_lowside <= stepper_pkg::DEF_BRIDGE_INVERT;
      clock_divisor <= stepper_pkg::DEF_CLOCK_DIVISOR;
    end else if (word_valid) begin
      if (!in_message) begin
        msg_op <= opcode;
        word_cnt <= 8'd1;
        reply_data <= '0;
        case (opcode)
          // Encoder snapshot goes back on the following words
          stepper_pkg::CMD_COORDINATED_STEP: reply_data <= encoder_count;
          stepper_pkg::CMD_MOTOR_ENABLE: enable <= word_data[stepper_pkg::MOTOR_COUNT-1:0];
          stepper_pkg::CMD_CLK_DIVISOR: clock_divisor <= word_data[7:0];
          stepper_pkg::CMD_MOTORCONFIG: begin
            current <= word_data[15:8];
            microsteps <= word_data[2:0];
          end
          stepper_pkg::CMD_MICROSTEPPER_CONFIG: begin
            config_offtime <= word_data[49:40];
            config_blanktime <= word_data[39:32];
            config_fastdecay_threshold <= word_data[31:22];
            config_minimum_on_time <= word_data[21:14];
            config_current_threshold <= word_data[10:0];
          end
          stepper_pkg::CMD_CHARGEPUMP: config_chargepump_period <= word_data[7:0];
          stepper_pkg::CMD_BRIDGEINVERT: begin
            config_invert_highside <= word_data[1];
            config_invert_lowside <= word_data[0];
          end
          stepper_pkg::CMD_API_VERSION: begin
            reply_data <= {40'd0, stepper_pkg::VERSION_MAJOR, stepper_pkg::VERSION_MINOR,
                           stepper_pkg::VERSION_PATCH};
          end
          default: ;
        endcase
      end else if (!in_move || move_commit) begin
        // Last word of a message
        msg_op <= '0;
        word_cnt <= '0;
        reply_data <= '0;
        if (move_commit) begin
          step_ready[write_index] <= ~step_ready[write_index];
          write_index <= write_index + 1'b1;
        end
      end else begin
        word_cnt <= word_cnt + 8'd1;
      end
    end
  end

  // Host ignored buffer_dtr and overwrote a slot the timers still run
  a_no_overwrite: assert property (@(posedge CLK) disable iff (!resetn)
    move_commit |-> step_ready[write_index] == step_finished[write_index])
    else $error("move written into busy slot %0d", write_index);

endmodule

// File: rtl/dda_timer.sv
`timescale 1ns/1ps

module dda_timer (
  input  logic                               CLK,
  input  logic                               resetn,
  input  logic [7:0]                         clock_divisor,
  input  logic [63:0]                        move_duration,
  input  logic [63:0]                        increment,
  input  logic [63:0]                        increment_increment,
  input  logic [stepper_pkg::MOVE_SLOTS-1:0] step_ready,
  input  logic [stepper_pkg::SLOT_BITS-1:0]  move_index,
  output logic                               step,
  output logic [stepper_pkg::MOVE_SLOTS-1:0] step_finished,
  output logic [stepper_pkg::SLOT_BITS-1:0]  move_index_out,
  output logic                               move_done
);

  logic [7:0] div_cnt;
  logic [63:0] tick_cnt;
  logic [63:0] position;
  logic [63:0] rate;
  logic [stepper_pkg::STEP_CARRY_BIT:0] low_sum;

  wire slot_active = step_ready[move_index] != step_finished[move_index];
  wire tick = slot_active && (div_cnt == clock_divisor);
  wire last_tick = tick && (tick_cnt + 64'd1 == move_duration);

  // First tick works from the slot values, later ones from the running state
  wire first_tick = tick_cnt == 64'd0;
  wire [63:0] cur_position = first_tick ? 64'd0 : position;
  wire [63:0] cur_rate = first_tick ? increment : rate;

  assign low_sum = {1'b0, cur_position[stepper_pkg::STEP_CARRY_BIT-1:0]} +
                   {1'b0, cur_rate[stepper_pkg::STEP_CARRY_BIT-1:0]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_cnt <= '0;
      tick_cnt <= '0;
      step_finished <= '0;
      move_index_out <= '0;
      step <= 1'b0;
      move_done <= 1'b0;
    end else begin
      step <= tick && low_sum[stepper_pkg::STEP_CARRY_BIT];
      move_done <= last_tick;
      if (!slot_active || tick) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 8'd1;
      end
      // Hand the slot back and move on to the next one
      if (last_tick) begin
        tick_cnt <= '0;
        step_finished[move_index] <= ~step_finished[move_index];
        move_index_out <= move_index + 1'b1;
      end else if (tick) begin
        tick_cnt <= tick_cnt + 64'd1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (tick) begin
      position <= cur_position + cur_rate;
      rate <= cur_rate + increment_increment;
    end
  end

  // Ticks are spaced apart unless the divisor is zero
  a_step_single: assert property (@(posedge CLK) disable iff (!resetn)
    (step && clock_divisor != 8'd0) |=> !step)
    else $error("step high on consecutive cycles");

endmodule

// File: rtl/stepper_controller_top.sv
`timescale 1ns/1ps

module stepper_controller_top (
  input  logic                                CLK,
  input  logic                                resetn,
  input  logic                                sck,
  input  logic                                cs,
  input  logic                                copi,
  input  logic [63:0]                         encoder_count,
  output logic                                cipo,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] step,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] dir,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] enable,
  output logic                                buffer_dtr,
  output logic                                move_done,
  output logic [2:0]                          microsteps,
  output logic [7:0]                          current,
  output logic [9:0]                          config_offtime,
  output logic [7:0]                          config_blanktime,
  output logic [9:0]                          config_fastdecay_threshold,
  output logic [7:0]                          config_minimum_on_time,
  output logic [10:0]                         config_current_threshold,
  output logic [7:0]                          config_chargepump_period,
  output logic                                config_invert_highside,
  output logic                                config_invert_lowside,
  output logic [7:0]                          clock_divisor
);

  logic [stepper_pkg::WORD_BITS-1:0] word_data;
  logic word_valid;
  logic [stepper_pkg::WORD_BITS-1:0] reply_data;
  logic [stepper_pkg::MOVE_SLOTS-1:0] step_ready;
  logic [stepper_pkg::MOVE_SLOTS-1:0] step_finished;
  logic [stepper_pkg::SLOT_BITS-1:0] move_index;
  logic [63:0] move_duration;
  logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] increment;
  logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] increment_increment;

  spi_word u_spi_word (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi),
    .reply_data(reply_data), .cipo(cipo), .word_data(word_data), .word_valid(word_valid)
  );

  spi_command_decoder u_spi_command_decoder (
    .CLK(CLK), .resetn(resetn), .word_data(word_data), .word_valid(word_valid),
    .encoder_count(encoder_count), .step_finished(step_finished), .move_index(move_index),
    .reply_data(reply_data), .enable(enable), .microsteps(microsteps), .current(current),
    .config_offtime(config_offtime), .config_blanktime(config_blanktime),
    .config_fastdecay_threshold(config_fastdecay_threshold),
    .config_minimum_on_time(config_minimum_on_time),
    .config_current_threshold(config_current_threshold),
    .config_chargepump_period(config_chargepump_period),
    .config_invert_highside(config_invert_highside),
    .config_invert_lowside(config_invert_lowside), .clock_divisor(clock_divisor),
    .step_ready(step_ready), .write_index(), .move_duration(move_duration),
    .increment(increment), .increment_increment(increment_increment), .dir(dir),
    .buffer_dtr(buffer_dtr)
  );

  // Axis 0 owns the slot handshake, the others follow its move_index
  for (genvar a = 0; a < stepper_pkg::MOTOR_COUNT; a++) begin : g_axis
    if (a == 0) begin : g_lead
      dda_timer u_dda_timer (
        .CLK(CLK), .resetn(resetn), .clock_divisor(clock_divisor),
        .move_duration(move_duration), .increment(increment[a]),
        .increment_increment(increment_increment[a]), .step_ready(step_ready),
        .move_index(move_index), .step(step[a]), .step_finished(step_finished),
        .move_index_out(move_index), .move_done(move_done)
      );
    end else begin : g_follow
      dda_timer u_dda_timer (
        .CLK(CLK), .resetn(resetn), .clock_divisor(clock_divisor),
        .move_duration(move_duration), .increment(increment[a]),
        .increment_increment(increment_increment[a]), .step_ready(step_ready),
        .move_index(move_index), .step(step[a]), .step_finished(),
        .move_index_out(), .move_done()
      );
    end
  end

endmodule

// File: verification/stepper_controller_tb.sv
`timescale 1ns/1ps

module stepper_controller_tb;

  localparam int AXES = stepper_pkg::MOTOR_COUNT;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic [63:0] encoder_count;
  logic cipo;
  logic [AXES-1:0] step;
  logic [AXES-1:0] dir;
  logic [AXES-1:0] enable;
  logic buffer_dtr;
  logic move_done;
  logic [2:0] microsteps;
  logic [7:0] current;
  logic [9:0] config_offtime;
  logic [7:0] config_blanktime;
  logic [9:0] config_fastdecay_threshold;
  logic [7:0] config_minimum_on_time;
  logic [10:0] config_current_threshold;
  logic [7:0] config_chargepump_period;
  logic config_invert_highside;
  logic config_invert_lowside;
  logic [7:0] clock_divisor;

  // Expected register model, starts at the reset defaults
  logic [AXES-1:0] exp_enable = '0;
  logic [2:0] exp_microsteps = stepper_pkg::DEF_MICROSTEPS;
  logic [7:0] exp_current = stepper_pkg::DEF_CURRENT;
  logic [9:0] exp_offtime = stepper_pkg::DEF_OFFTIME;
  logic [7:0] exp_blanktime = stepper_pkg::DEF_BLANKTIME;
  logic [9:0] exp_fastdecay = stepper_pkg::DEF_FASTDECAY;
  logic [7:0] exp_min_on_time = stepper_pkg::DEF_MIN_ON_TIME;
  logic [10:0] exp_current_threshold = stepper_pkg::DEF_CURRENT_THRESHOLD;
  logic [7:0] exp_chargepump = stepper_pkg::DEF_CHARGEPUMP;
  logic exp_invert_highside = stepper_pkg::DEF_BRIDGE_INVERT;
  logic exp_invert_lowside = stepper_pkg::DEF_BRIDGE_INVERT;
  logic [7:0] exp_divisor = stepper_pkg::DEF_CLOCK_DIVISOR;

  logic [31:0] lfsr_state = 32'hb298;
  int error_count = 0;
  int check_count = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int errors_before = 0;
  bit chk_valid = 1'b0;
  string chk_tag;
  logic [127:0] chk_got;
  logic [127:0] chk_exp;
  bit dir_check_on = 1'b0;
  bit idle_check_on = 1'b0;
  logic [AXES-1:0] exp_dir;
  int step_count [AXES];
  int done_count = 0;
  logic [63:0] last_reply;
  logic [63:0] reply_words [2*AXES+2];

  wire [AXES+75:0] dut_config = {enable, microsteps, current, config_offtime, config_blanktime,
    config_fastdecay_threshold, config_minimum_on_time, config_current_threshold,
    config_chargepump_period, config_invert_highside, config_invert_lowside, clock_divisor};

  stepper_controller_top u_stepper_controller_top (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Pulse counters, sampled mid-cycle
  always @(negedge CLK) begin
    for (int a = 0; a < AXES; a++) begin
      if (step[a]) step_count[a]++;
    end
    if (move_done) done_count++;
  end

  check_match: assert property (@(posedge CLK) chk_valid |-> chk_got == chk_exp)
    else begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, chk_tag, chk_got, chk_exp);
      error_count++;
    end

  dir_follows_header: assert property (@(posedge CLK) dir_check_on |-> dir == exp_dir)
    else begin
      $display("[ERROR] %0t dir is %b during the move, header gave %b", $time, dir, exp_dir);
      error_count++;
    end

  stays_idle: assert property (@(posedge CLK) idle_check_on |-> (step == '0 && !move_done))
    else begin
      $display("[ERROR] %0t step or move_done active with no move queued", $time);
      error_count++;
    end

  // Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
  function automatic logic [63:0] lfsr_bits(input int count);
    logic [63:0] value;
    logic feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value = {value[62:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [AXES+75:0] expected_config();
    return {exp_enable, exp_microsteps, exp_current, exp_offtime, exp_blanktime,
            exp_fastdecay, exp_min_on_time, exp_current_threshold, exp_chargepump,
            exp_invert_highside, exp_invert_lowside, exp_divisor};
  endfunction

  // Steps counted as advances of the accumulator's upper half over all ticks
  function automatic logic [63:0] carry_steps(input logic [63:0] duration,
                                              input logic [63:0] inc,
                                              input logic [63:0] inc_inc);
    logic [63:0] position;
    logic [63:0] rate;
    logic [31:0] upper_before;
    logic [63:0] total;
    position = '0;
    rate = inc;
    total = '0;
    for (longint unsigned t = 0; t < duration; t++) begin
      upper_before = position[63:32];
      position = position + rate;
      total = total + 64'(position[63:32] - upper_before);
      rate = rate + inc_inc;
    end
    return total;
  endfunction

  // SPI mode 0, four CLK cycles per SCK half period
  task automatic exchange_word(input logic [63:0] tx);
    @(negedge CLK);
    cs = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      copi = tx[i];
      repeat (4) @(negedge CLK);
      last_reply[i] = cipo;
      sck = 1'b1;
      repeat (4) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (4) @(negedge CLK);
    cs = 1'b1;
    copi = 1'b0;
    repeat (8) @(negedge CLK);
  endtask

  task automatic send_command(input logic [7:0] opcode, output logic [55:0] fields);
    fields = 56'(lfsr_bits(56));
    exchange_word({opcode, fields});
  endtask

  task automatic set_divisor(input logic [7:0] value);
    exchange_word({stepper_pkg::CMD_CLK_DIVISOR, 48'd0, value});
    exp_divisor = value;
  endtask

  task automatic check_value(input string tag, input logic [127:0] got,
                             input logic [127:0] expected);
    @(negedge CLK);
    chk_tag = tag;
    chk_got = got;
    chk_exp = expected;
    chk_valid = 1'b1;
    check_count++;
    @(negedge CLK);
    chk_valid = 1'b0;
  endtask

  task automatic wait_buffer_free(input int limit);
    int waited = 0;
    while (!buffer_dtr && waited < limit) begin
      @(negedge CLK);
      waited++;
    end
    if (!buffer_dtr) begin
      $display("Timed out after %0d cycles waiting for a free move slot at %0t", limit, $time);
      error_count++;
    end
  endtask

  task automatic wait_move_done(input int limit);
    int waited = 0;
    do begin
      @(negedge CLK);
      waited++;
    end while (!move_done && waited < limit);
    if (!move_done) begin
      $display("Timed out after %0d cycles waiting for move_done at %0t", limit, $time);
      error_count++;
    end
  endtask

  // Header, duration, then increment and increment-increment per axis
  task automatic send_move(input logic [63:0] duration, input logic [AXES-1:0][63:0] inc,
                           input logic [AXES-1:0][63:0] inc_inc, input logic [AXES-1:0] dirs);
    wait_buffer_free(20000);
    exchange_word({stepper_pkg::CMD_COORDINATED_STEP, 56'(dirs)});
    reply_words[0] = last_reply;
    // Encoder moves on after the header, the snapshot must not
    encoder_count = lfsr_bits(64);
    exchange_word(duration);
    reply_words[1] = last_reply;
    for (int a = 0; a < AXES; a++) begin
      exchange_word(inc[a]);
      reply_words[2*a+2] = last_reply;
      exchange_word(inc_inc[a]);
      reply_words[2*a+3] = last_reply;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count != errors_before) begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    errors_before = error_count;
  endtask

  initial begin
    logic [55:0] fields;
    logic [63:0] duration;
    logic [63:0] snapshot;
    logic [AXES-1:0][63:0] inc;
    logic [AXES-1:0][63:0] inc_inc;
    logic [AXES-1:0] dirs;
    int base_steps [AXES];
    int base_done;
    resetn = 1'b0;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    encoder_count = '0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b1;

    idle_check_on = 1'b1;
    check_value("config after reset", dut_config, expected_config());
    check_value("buffer_dtr after reset", buffer_dtr, 1'b1);
    check_value("step and move_done after reset", {step, move_done}, '0);
    finish_test("reset state");

    send_command(stepper_pkg::CMD_MOTOR_ENABLE, fields);
    exp_enable = fields[AXES-1:0];
    check_value("enable command", dut_config, expected_config());
    send_command(stepper_pkg::CMD_CLK_DIVISOR, fields);
    exp_divisor = fields[7:0];
    check_value("divisor command", dut_config, expected_config());
    send_command(stepper_pkg::CMD_MOTORCONFIG, fields);
    exp_current = fields[15:8];
    exp_microsteps = fields[2:0];
    check_value("motor config command", dut_config, expected_config());
    send_command(stepper_pkg::CMD_MICROSTEPPER_CONFIG, fields);
    exp_offtime = fields[49:40];
    exp_blanktime = fields[39:32];
    exp_fastdecay = fields[31:22];
    exp_min_on_time = fields[21:14];
    exp_current_threshold = fields[10:0];
    check_value("microstepper config command", dut_config, expected_config());
    send_command(stepper_pkg::CMD_CHARGEPUMP, fields);
    exp_chargepump = fields[7:0];
    check_value("charge pump command", dut_config, expected_config());
    send_command(stepper_pkg::CMD_BRIDGEINVERT, fields);
    exp_invert_highside = fields[1];
    exp_invert_lowside = fields[0];
    check_value("bridge invert command", dut_config, expected_config());
    finish_test("single-word commands");

    exchange_word({stepper_pkg::CMD_API_VERSION, 56'(lfsr_bits(56))});
    exchange_word(lfsr_bits(64));
    check_value("version reply", last_reply, {40'd0, stepper_pkg::VERSION_MAJOR,
                stepper_pkg::VERSION_MINOR, stepper_pkg::VERSION_PATCH});
    idle_check_on = 1'b0;
    finish_test("api version");

    set_divisor(8'd2);
    encoder_count = lfsr_bits(64);
    snapshot = encoder_count;
    duration = 64'd200 + lfsr_bits(6);
    for (int a = 0; a < AXES; a++) begin
      inc[a] = lfsr_bits(32);
      inc_inc[a] = '0;
      base_steps[a] = step_count[a];
    end
    dirs = AXES'(lfsr_bits(AXES));
    send_move(duration, inc, inc_inc, dirs);
    exp_dir = dirs;
    dir_check_on = 1'b1;
    for (int w = 1; w < 2 * AXES + 2; w++) begin
      check_value("encoder snapshot", reply_words[w], snapshot);
    end
    wait_move_done(2000);
    dir_check_on = 1'b0;
    repeat (4) @(negedge CLK);
    for (int a = 0; a < AXES; a++) begin
      check_value("constant-rate steps", step_count[a] - base_steps[a],
                  (duration * inc[a]) >> 32);
    end
    finish_test("coordinated move");

    set_divisor(8'd9);
    base_done = done_count;
    for (int a = 0; a < AXES; a++) begin
      inc[a] = lfsr_bits(32);
    end
    send_move(64'd600, inc, inc_inc, AXES'(lfsr_bits(AXES)));
    send_move(64'd100, inc, inc_inc, AXES'(lfsr_bits(AXES)));
    check_value("buffer_dtr with both slots busy", buffer_dtr, 1'b0);
    wait_move_done(8000);
    wait_move_done(2000);
    repeat (2) @(negedge CLK);
    check_value("buffer_dtr after both moves", buffer_dtr, 1'b1);
    check_value("move_done pulse count", done_count - base_done, 2);
    finish_test("back-to-back moves");

    set_divisor(8'd2);
    duration = 64'd150;
    for (int a = 0; a < AXES; a++) begin
      inc[a] = lfsr_bits(24);
      inc_inc[a] = lfsr_bits(20) + 64'd1;
      base_steps[a] = step_count[a];
    end
    send_move(duration, inc, inc_inc, AXES'(lfsr_bits(AXES)));
    wait_move_done(3000);
    repeat (4) @(negedge CLK);
    for (int a = 0; a < AXES; a++) begin
      check_value("accelerating steps", step_count[a] - base_steps[a],
                  carry_steps(duration, inc[a], inc_inc[a]));
    end
    finish_test("accelerating move");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: stepper_controller_top.f
rtl/stepper_pkg.sv
rtl/spi_word.sv
rtl/spi_command_decoder.sv
rtl/dda_timer.sv
rtl/stepper_controller_top.sv
verification/stepper_controller_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module stepper_controller_tb \
  -f stepper_controller_top.f --Mdir "$BUILD_DIR" -o sim_stepper
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_stepper" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
  exit 0
fi
exit 1
